//--- list.f
verilog/i2cPkg.sv
verilog/bitPhaseTimer.sv
verilog/busSignaling.sv
verilog/byteShifter.sv
verilog/i2cSequencer.sv
verilog/i2cMaster.sv
tests/i2cSlaveModel.sv
tests/i2cMasterTb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module i2cMasterTb \
    -f list.f --Mdir obj_dir -o simv || exit 1
out=$(./obj_dir/simv)
echo "$out"
echo "$out" | grep -q "^Test passed$" && exit 0 || exit 1

//--- tests/i2cMasterTb.sv
`timescale 1ns/1ps

module i2cMasterTb import i2cPkg::*; ;

    localparam logic [6:0]  SlaveAddr = 7'h3c;
    localparam logic [6:0]  WrongAddr = 7'h51;
    localparam logic [31:0] Seed      = 32'ha60b359a;
    localparam int          Timeout   = 20000;

    logic FSM_Clk;
    logic reset;
    logic cmdValid;
    logic cmdRead;
    logic [DevAddrWidth-1:0] devAddr;
    logic [ByteWidth-1:0] subAddr;
    logic [ByteWidth-1:0] wrData;
    logic [ReadCountWidth-1:0] readCount;
    logic rdReady;
    logic cmdReady;
    logic rdValid;
    logic [ByteWidth-1:0] rdData;
    logic doneValid;
    logic ackError;
    logic scl;
    logic sdaDriveLow;
    logic slaveSdaLow;
    logic protocolError;
    logic sdaLine;

    logic [7:0] shadow [256];
    logic [7:0] expRd [$];
    logic       expAck [$];
    int         doneCount;
    logic       inFlight;
    logic       randomReady;

    // Wired-AND of the open drain SDA
    assign sdaLine = !(sdaDriveLow || slaveSdaLow);

    i2cMaster UUT (
        .FSM_Clk(FSM_Clk), .reset(reset), .cmdValid(cmdValid), .cmdRead(cmdRead),
        .devAddr(devAddr), .subAddr(subAddr), .wrData(wrData), .readCount(readCount),
        .rdReady(rdReady), .sdaIn(sdaLine), .cmdReady(cmdReady), .rdValid(rdValid),
        .rdData(rdData), .doneValid(doneValid), .ackError(ackError), .scl(scl),
        .sdaDriveLow(sdaDriveLow)
    );

    i2cSlaveModel #(.DevAddr(SlaveAddr)) slave (
        .FSM_Clk(FSM_Clk), .reset(reset), .scl(scl), .sda(sdaLine),
        .masterLow(sdaDriveLow), .sdaLow(slaveSdaLow), .protocolError(protocolError)
    );

    initial begin
        FSM_Clk = 1'b0;
        forever #10 FSM_Clk = !FSM_Clk;
    end

    task automatic stopRun(string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic checkBit(string name, logic got, logic want);
        assert (got === want) else
            stopRun($sformatf("CHECK FAILED at %0t: %s = %b, expected %b", $time, name, got, want));
    endtask

    // Expected read bytes; a missing device leaves SDA released
    function automatic logic [7:0] expectedByte(logic [6:0] dev, logic [7:0] sub, int idx);
        if (dev != SlaveAddr) begin
            return 8'hff;
        end
        return shadow[8'(sub + idx)];
    endfunction

    task automatic sendCommand(logic rd, logic [6:0] dev, logic [7:0] sub, logic [7:0] data,
                               logic [3:0] count);
        int n;
        int cycles;
        n = (count == 0) ? 1 : count;
        if (rd) begin
            for (int i = 0; i < n; i++) begin
                expRd.push_back(expectedByte(dev, sub, i));
            end
        end else if (dev == SlaveAddr) begin
            shadow[sub] = data;
        end
        expAck.push_back(dev != SlaveAddr);
        cmdValid  = 1'b1;
        cmdRead   = rd;
        devAddr   = dev;
        subAddr   = sub;
        wrData    = data;
        readCount = count;
        cycles    = 0;
        while (!cmdReady) begin
            @(posedge FSM_Clk);
            #1;
            cycles++;
            if (cycles > Timeout) stopRun("Timed out waiting for cmdReady");
        end
        @(posedge FSM_Clk);
        #1;
        cmdValid = 1'b0;
    endtask

    task automatic waitDone(int target);
        int cycles;
        cycles = 0;
        while (doneCount < target) begin
            @(posedge FSM_Clk);
            #1;
            cycles++;
            if (cycles > Timeout) stopRun("Timed out waiting for doneValid");
        end
    endtask

    // Read handshake, optionally stalled at random
    initial begin
        rdReady = 1'b0;
        forever begin
            @(posedge FSM_Clk);
            #1;
            rdReady = randomReady ? ($urandom_range(0, 2) == 0) : 1'b1;
        end
    end

    always @(posedge FSM_Clk) begin : compare
        logic [7:0] want;
        logic       wantAck;
        if (!reset) begin
            assert (!protocolError) else stopRun("Slave model saw an I2C protocol violation");
            if (inFlight) checkBit("cmdReady", cmdReady, 1'b0);
            if (rdValid && rdReady) begin
                assert (expRd.size() > 0) else stopRun("Read byte arrived that was not expected");
                want = expRd.pop_front();
                assert (rdData == want) else
                    stopRun($sformatf("CHECK FAILED at %0t: rdData = %h, expected %h",
                                      $time, rdData, want));
            end
            if (doneValid) begin
                assert (inFlight && (expAck.size() > 0) && (expRd.size() == 0)) else
                    stopRun("doneValid came without a finished command");
                wantAck = expAck.pop_front();
                checkBit("ackError", ackError, wantAck);
                doneCount++;
                inFlight = 1'b0;
            end
            if (cmdValid && cmdReady) inFlight = 1'b1;
        end
    end

    initial begin
        logic [7:0] sub;
        logic [7:0] data;
        int         target;
        cmdValid    = 1'b0;
        cmdRead     = 1'b0;
        devAddr     = '0;
        subAddr     = '0;
        wrData      = '0;
        readCount   = '0;
        randomReady = 1'b0;
        doneCount   = 0;
        inFlight    = 1'b0;
        void'($urandom(Seed));
        for (int i = 0; i < 256; i++) begin
            shadow[i] = 8'((i * 37) + 11);
        end
        reset = 1'b1;
        repeat (10) @(posedge FSM_Clk);
        #1;
        reset = 1'b0;
        checkBit("cmdReady", cmdReady, 1'b1);
        checkBit("scl", scl, 1'b1);
        checkBit("sdaDriveLow", sdaDriveLow, 1'b0);
        checkBit("rdValid", rdValid, 1'b0);
        checkBit("doneValid", doneValid, 1'b0);
        checkBit("ackError", ackError, 1'b0);

        for (int i = 0; i < 6; i++) begin
            sub  = 8'($urandom);
            data = 8'($urandom);
            sendCommand(1'b0, SlaveAddr, sub, data, 4'd0);
            waitDone(doneCount + 1);
            sendCommand(1'b1, SlaveAddr, sub, 8'h00, 4'd1);
            waitDone(doneCount + 1);
        end

        randomReady = 1'b1;
        for (int i = 0; i < 4; i++) begin
            sendCommand(1'b1, SlaveAddr, 8'($urandom), 8'h00, 4'($urandom_range(1, 15)));
            waitDone(doneCount + 1);
        end
        // Zero count reads one byte
        sendCommand(1'b1, SlaveAddr, 8'hfe, 8'h00, 4'd0);
        waitDone(doneCount + 1);
        sendCommand(1'b0, WrongAddr, 8'h10, 8'h77, 4'd0);
        waitDone(doneCount + 1);
        sendCommand(1'b1, WrongAddr, 8'h10, 8'h00, 4'd3);
        waitDone(doneCount + 1);
        randomReady = 1'b0;

        // Command raised while busy must be ignored
        sendCommand(1'b1, SlaveAddr, 8'h20, 8'h00, 4'd2);
        target = doneCount + 1;
        repeat (40) @(posedge FSM_Clk);
        #1;
        cmdValid = 1'b1;
        cmdRead  = 1'b0;
        devAddr  = SlaveAddr;
        repeat (30) @(posedge FSM_Clk);
        #1;
        cmdValid = 1'b0;
        waitDone(target);
        for (int i = 0; i < 200; i++) begin
            @(posedge FSM_Clk);
            #1;
            checkBit("scl", scl, 1'b1);
            checkBit("sdaDriveLow", sdaDriveLow, 1'b0);
        end

        if ((expRd.size() == 0) && (expAck.size() == 0)) begin
            $display("Test passed");
            $finish;
        end else begin
            stopRun("Expected read bytes or completions never arrived");
        end
    end

endmodule

//--- tests/i2cSlaveModel.sv
`timescale 1ns/1ps

module i2cSlaveModel #(
    parameter logic [6:0] DevAddr = 7'h3c
) (
    input  logic FSM_Clk,
    input  logic reset,
    input  logic scl,
    input  logic sda,
    input  logic masterLow,
    output logic sdaLow,
    output logic protocolError
);

    typedef enum {ModeIdle, ModeAddr, ModeSub, ModeWrite, ModeRead, ModeIgnore} mode_t;

    logic [7:0] regs [256];
    logic [7:0] ptr;
    logic [7:0] shiftIn;
    logic [7:0] txByte;
    logic [3:0] bitCnt;
    logic       prevScl;
    logic       prevSda;
    logic       addrMatch;
    logic       readDir;
    logic       startSeen;
    mode_t      mode;

    initial begin
        for (int i = 0; i < 256; i++) begin
            regs[i] = 8'((i * 37) + 11);
        end
    end

    always @(posedge FSM_Clk) begin
        if (reset) begin
            mode          <= ModeIdle;
            bitCnt        <= '0;
            sdaLow        <= 1'b0;
            protocolError <= 1'b0;
            prevScl       <= 1'b1;
            prevSda       <= 1'b1;
            ptr           <= '0;
            startSeen     <= 1'b0;
        end else begin
            prevScl <= scl;
            prevSda <= sda;
            if (prevScl && scl && (sda != prevSda)) begin
                // Start or stop; anything mid-byte is illegal
                if (bitCnt != 0) begin
                    protocolError <= 1'b1;
                end
                mode      <= sda ? ModeIdle : ModeAddr;
                bitCnt    <= '0;
                shiftIn   <= '0;
                sdaLow    <= 1'b0;
                startSeen <= !sda;
            end else if (!prevScl && scl) begin
                if (bitCnt < 8) begin
                    if (mode == ModeRead) begin
                        if (masterLow) protocolError <= 1'b1;
                    end else begin
                        shiftIn <= {shiftIn[6:0], sda};
                    end
                end else begin
                    case (mode)
                        ModeRead: if (sda) mode <= ModeIgnore;
                        ModeIgnore, ModeIdle: ;
                        // Our acknowledge slot, master must release
                        default: if (masterLow) protocolError <= 1'b1;
                    endcase
                end
            end else if (prevScl && !scl) begin
                if (startSeen) begin
                    // First fall after a start carries no bit
                    startSeen <= 1'b0;
                end else if (bitCnt < 7) begin
                    bitCnt <= bitCnt + 1'b1;
                    if (mode == ModeRead) begin
                        sdaLow <= !txByte[6];
                        txByte <= txByte << 1;
                    end
                end else if (bitCnt == 7) begin
                    bitCnt <= 4'd8;
                    case (mode)
                        ModeAddr: begin
                            addrMatch <= (shiftIn[7:1] == DevAddr);
                            readDir   <= shiftIn[0];
                            sdaLow    <= (shiftIn[7:1] == DevAddr);
                        end
                        ModeSub: begin
                            ptr    <= shiftIn;
                            sdaLow <= 1'b1;
                        end
                        ModeWrite: begin
                            regs[ptr] <= shiftIn;
                            ptr       <= ptr + 1'b1;
                            sdaLow    <= 1'b1;
                        end
                        default: sdaLow <= 1'b0;
                    endcase
                end else begin
                    bitCnt <= '0;
                    sdaLow <= 1'b0;
                    if ((mode == ModeRead) || ((mode == ModeAddr) && addrMatch && readDir)) begin
                        mode   <= ModeRead;
                        txByte <= regs[ptr];
                        ptr    <= ptr + 1'b1;
                        sdaLow <= !regs[ptr][7];
                    end else if (mode == ModeAddr) begin
                        mode <= addrMatch ? ModeSub : ModeIgnore;
                    end else if (mode == ModeSub) begin
                        mode <= ModeWrite;
                    end
                end
            end
        end
    end

endmodule

//--- verilog/i2cMaster.sv
`timescale 1ns/1ps

module i2cMaster import i2cPkg::*; (
    input  logic                      FSM_Clk,
    input  logic                      reset,
    input  logic                      cmdValid,
    input  logic                      cmdRead,
    input  logic [DevAddrWidth-1:0]   devAddr,
    input  logic [ByteWidth-1:0]      subAddr,
    input  logic [ByteWidth-1:0]      wrData,
    input  logic [ReadCountWidth-1:0] readCount,
    input  logic                      rdReady,
    input  logic                      sdaIn,
    output logic                      cmdReady,
    output logic                      rdValid,
    output logic [ByteWidth-1:0]      rdData,
    output logic                      doneValid,
    output logic                      ackError,
    output logic                      scl,
    output logic                      sdaDriveLow
);

    logic                 run;
    phase_t               phase;
    logic                 phaseTick;
    logic                 slotEnd;
    slotKind_t            slotKind;
    logic                 txBit;
    logic                 sampledBit;
    logic                 load;
    logic [ByteWidth-1:0] loadByte;
    logic                 shift;
    logic                 outBit;
    logic [ByteWidth-1:0] byteOut;

    i2cSequencer sequencer (
        .FSM_Clk    (FSM_Clk),
        .reset      (reset),
        .cmdValid   (cmdValid),
        .cmdRead    (cmdRead),
        .devAddr    (devAddr),
        .subAddr    (subAddr),
        .wrData     (wrData),
        .readCount  (readCount),
        .rdReady    (rdReady),
        .slotEnd    (slotEnd),
        .sampledBit (sampledBit),
        .outBit     (outBit),
        .byteOut    (byteOut),
        .cmdReady   (cmdReady),
        .rdValid    (rdValid),
        .rdData     (rdData),
        .doneValid  (doneValid),
        .ackError   (ackError),
        .run        (run),
        .slotKind   (slotKind),
        .txBit      (txBit),
        .load       (load),
        .loadByte   (loadByte),
        .shift      (shift)
    );

    bitPhaseTimer phaseTimer (
        .FSM_Clk   (FSM_Clk),
        .reset     (reset),
        .run       (run),
        .phase     (phase),
        .phaseTick (phaseTick),
        .slotEnd   (slotEnd)
    );

    busSignaling lines (
        .FSM_Clk     (FSM_Clk),
        .reset       (reset),
        .slotKind    (slotKind),
        .txBit       (txBit),
        .phase       (phase),
        .phaseTick   (phaseTick),
        .sdaIn       (sdaIn),
        .scl         (scl),
        .sdaDriveLow (sdaDriveLow),
        .sampledBit  (sampledBit)
    );

    byteShifter shifter (
        .FSM_Clk    (FSM_Clk),
        .reset      (reset),
        .load       (load),
        .loadByte   (loadByte),
        .shift      (shift),
        .sampledBit (sampledBit),
        .outBit     (outBit),
        .byteOut    (byteOut)
    );

endmodule

//--- verilog/i2cSequencer.sv
`timescale 1ns/1ps

module i2cSequencer import i2cPkg::*; (
    input  logic                      FSM_Clk,
    input  logic                      reset,
    input  logic                      cmdValid,
    input  logic                      cmdRead,
    input  logic [DevAddrWidth-1:0]   devAddr,
    input  logic [ByteWidth-1:0]      subAddr,
    input  logic [ByteWidth-1:0]      wrData,
    input  logic [ReadCountWidth-1:0] readCount,
    input  logic                      rdReady,
    input  logic                      slotEnd,
    input  logic                      sampledBit,
    input  logic                      outBit,
    input  logic [ByteWidth-1:0]      byteOut,
    output logic                      cmdReady,
    output logic                      rdValid,
    output logic [ByteWidth-1:0]      rdData,
    output logic                      doneValid,
    output logic                      ackError,
    output logic                      run,
    output slotKind_t                 slotKind,
    output logic                      txBit,
    output logic                      load,
    output logic [ByteWidth-1:0]      loadByte,
    output logic                      shift
);

    seqState_t                 state;
    logic [3:0]                bitCount;
    logic [ReadCountWidth-1:0] bytesLeft;
    logic                      cmdAccept;
    logic                      ackSlot;
    logic                      sendState;
    logic                      lastRead;

    logic                      cmdIsRead;
    logic [DevAddrWidth-1:0]   cmdDevAddr;
    logic [ByteWidth-1:0]      cmdSubAddr;
    logic [ByteWidth-1:0]      cmdWrData;

    assign cmdReady  = (state == SeqIdle);
    assign cmdAccept = cmdValid && cmdReady;
    assign sendState = state inside {SeqAddr, SeqSubAddr, SeqWrData, SeqRdAddr};
    assign ackSlot   = sendState && (int'(bitCount) == ByteWidth);
    assign lastRead  = (bytesLeft == ReadCountWidth'(1));

    // Timer stalls with SCL low while a read byte waits
    assign run = !(state inside {SeqIdle, SeqWaitAccept, SeqDone});

    always_comb begin
        case (state)
            SeqStart:     slotKind = SlotStart;
            SeqRepStart:  slotKind = SlotRepStart;
            SeqStop:      slotKind = SlotStop;
            SeqIdle,
            SeqDone:      slotKind = SlotIdle;
            default:      slotKind = SlotData;
        endcase
    end

    always_comb begin
        if (sendState) begin
            txBit = ackSlot ? 1'b1 : outBit;
        end else if (state == SeqMasterAck) begin
            // NACK on the final byte
            txBit = lastRead;
        end else begin
            txBit = 1'b1;
        end
    end

    always_comb begin
        case (state)
            SeqStart:    loadByte = {cmdDevAddr, 1'b0};
            SeqAddr:     loadByte = cmdSubAddr;
            SeqRepStart: loadByte = {cmdDevAddr, 1'b1};
            default:     loadByte = cmdWrData;
        endcase
    end

    assign load = slotEnd && ((state == SeqStart) || (state == SeqRepStart) ||
                  (ackSlot && (state == SeqAddr)) ||
                  (ackSlot && (state == SeqSubAddr) && !cmdIsRead));

    assign shift = slotEnd && (int'(bitCount) < ByteWidth) &&
                   (sendState || (state == SeqRdData));

    always_ff @(posedge FSM_Clk) begin
        if (reset) begin
            state     <= SeqIdle;
            bitCount  <= '0;
            bytesLeft <= '0;
            ackError  <= 1'b0;
            rdValid   <= 1'b0;
            doneValid <= 1'b0;
        end else begin
            doneValid <= 1'b0;
            case (state)
                SeqIdle: begin
                    if (cmdAccept) begin
                        state     <= SeqStart;
                        ackError  <= 1'b0;
                        bytesLeft <= (readCount == '0) ? ReadCountWidth'(1) : readCount;
                    end
                end
                SeqStart, SeqRepStart: begin
                    if (slotEnd) begin
                        bitCount <= '0;
                        state    <= (state == SeqStart) ? SeqAddr : SeqRdAddr;
                    end
                end
                SeqAddr, SeqSubAddr, SeqWrData, SeqRdAddr: begin
                    if (slotEnd && ackSlot) begin
                        bitCount <= '0;
                        // SDA high in the ack slot means NACK
                        if (sampledBit) begin
                            ackError <= 1'b1;
                        end
                        case (state)
                            SeqAddr:    state <= SeqSubAddr;
                            SeqSubAddr: state <= cmdIsRead ? SeqRepStart : SeqWrData;
                            SeqRdAddr:  state <= SeqRdData;
                            default:    state <= SeqStop;
                        endcase
                    end else if (slotEnd) begin
                        bitCount <= bitCount + 1'b1;
                    end
                end
                SeqRdData: begin
                    if (slotEnd) begin
                        if (int'(bitCount) == ByteWidth - 1) begin
                            bitCount <= '0;
                            state    <= SeqWaitAccept;
                        end else begin
                            bitCount <= bitCount + 1'b1;
                        end
                    end
                end
                SeqWaitAccept: begin
                    if (!rdValid) begin
                        rdValid <= 1'b1;
                    end else if (rdReady) begin
                        rdValid <= 1'b0;
                        state   <= SeqMasterAck;
                    end
                end
                SeqMasterAck: begin
                    if (slotEnd) begin
                        if (lastRead) begin
                            state <= SeqStop;
                        end else begin
                            bytesLeft <= bytesLeft - 1'b1;
                            state     <= SeqRdData;
                        end
                    end
                end
                SeqStop: begin
                    if (slotEnd) begin
                        doneValid <= 1'b1;
                        state     <= SeqDone;
                    end
                end
                SeqDone: begin
                    state <= SeqIdle;
                end
                default: begin
                    state <= SeqIdle;
                end
            endcase
        end
    end

    // Command fields and the received byte
    always_ff @(posedge FSM_Clk) begin
        if (cmdAccept) begin
            cmdIsRead  <= cmdRead;
            cmdDevAddr <= devAddr;
            cmdSubAddr <= subAddr;
            cmdWrData  <= wrData;
        end
        if ((state == SeqWaitAccept) && !rdValid) begin
            rdData <= byteOut;
        end
    end

endmodule

//--- verilog/byteShifter.sv
`timescale 1ns/1ps

module byteShifter import i2cPkg::*; (
    input  logic                 FSM_Clk,
    input  logic                 reset,
    input  logic                 load,
    input  logic [ByteWidth-1:0] loadByte,
    input  logic                 shift,
    input  logic                 sampledBit,
    output logic                 outBit,
    output logic [ByteWidth-1:0] byteOut
);

    logic [ByteWidth-1:0] shiftReg;

    always_ff @(posedge FSM_Clk) begin
        if (reset) begin
            // All ones so an unloaded shifter leaves SDA released
            shiftReg <= '1;
        end else if (load) begin
            shiftReg <= loadByte;
        end else if (shift) begin
            shiftReg <= {shiftReg[ByteWidth-2:0], sampledBit};
        end
    end

    // MSB goes out first
    assign outBit  = shiftReg[ByteWidth-1];
    assign byteOut = shiftReg;

endmodule

//--- verilog/busSignaling.sv
`timescale 1ns/1ps

module busSignaling import i2cPkg::*; (
    input  logic      FSM_Clk,
    input  logic      reset,
    input  slotKind_t slotKind,
    input  logic      txBit,
    input  phase_t    phase,
    input  logic      phaseTick,
    input  logic      sdaIn,
    output logic      scl,
    output logic      sdaDriveLow,
    output logic      sampledBit
);

    always_ff @(posedge FSM_Clk) begin
        if (reset) begin
            scl         <= 1'b1;
            sdaDriveLow <= 1'b0;
        end else begin
            case (slotKind)
                SlotStart: begin
                    // SDA falls in phase 1 with SCL still high
                    scl         <= (phase != 2'd3);
                    sdaDriveLow <= (phase != 2'd0);
                end
                SlotRepStart: begin
                    scl         <= (phase == 2'd1) || (phase == 2'd2);
                    sdaDriveLow <= phase[1];
                end
                SlotData: begin
                    scl <= (phase == 2'd1) || (phase == 2'd2);
                    // Data only moves while SCL is low
                    if (phase == 2'd0) begin
                        sdaDriveLow <= !txBit;
                    end
                end
                SlotStop: begin
                    // SDA released in phase 2 with SCL high
                    scl         <= (phase != 2'd0);
                    sdaDriveLow <= !phase[1];
                end
                default: begin
                    scl         <= 1'b1;
                    sdaDriveLow <= 1'b0;
                end
            endcase
        end
    end

    // Sample at the end of the second high phase
    always_ff @(posedge FSM_Clk) begin
        if (phaseTick && (phase == 2'd2)) begin
            sampledBit <= sdaIn;
        end
    end

endmodule

//--- verilog/bitPhaseTimer.sv
`timescale 1ns/1ps

module bitPhaseTimer import i2cPkg::*; (
    input  logic   FSM_Clk,
    input  logic   reset,
    input  logic   run,
    output phase_t phase,
    output logic   phaseTick,
    output logic   slotEnd
);

    logic [$clog2(QuarterCycles)-1:0] divCount;

    // Last cycle of the current phase
    assign phaseTick = run && (int'(divCount) == QuarterCycles - 1);
    assign slotEnd   = phaseTick && (int'(phase) == PhasesPerBit - 1);

    always_ff @(posedge FSM_Clk) begin
        if (reset) begin
            divCount <= '0;
            phase    <= '0;
        end else if (run) begin
            if (phaseTick) begin
                divCount <= '0;
                phase    <= slotEnd ? '0 : phase + 1'b1;
            end else begin
                divCount <= divCount + 1'b1;
            end
        end
    end

    // Counters freeze while run is low, and the sequencer only drops run
    // at a slot boundary, so a stalled slot always resumes in phase 0

endmodule

//--- verilog/i2cPkg.sv
package i2cPkg;

    // Bus field widths
    localparam int ByteWidth      = 8;
    localparam int DevAddrWidth   = 7;
    localparam int ReadCountWidth = 4;

    // Bit timing, in FSM_Clk cycles per phase and phases per slot
    localparam int QuarterCycles = 4;
    localparam int PhasesPerBit  = 4;

    typedef logic [1:0] phase_t;

    typedef enum logic [2:0] {
        SlotIdle,
        SlotStart,
        SlotRepStart,
        SlotData,
        SlotStop
    } slotKind_t;

    typedef enum logic [3:0] {
        SeqIdle,
        SeqStart,
        SeqAddr,
        SeqSubAddr,
        SeqWrData,
        SeqRepStart,
        SeqRdAddr,
        SeqRdData,
        SeqMasterAck,
        SeqWaitAccept,
        SeqStop,
        SeqDone
    } seqState_t;

endpackage
